// File: hw/binning_pkg.sv
`default_nettype none

package binning_pkg;

  localparam int WEIGHT_W    = 32;  // weight and bus data width
  localparam int ADDR_W      = 32;
  localparam int LEN_W       = 20;  // burst length in bytes
  localparam int BIN_FIELD_W = 8;   // room for up to 256 bins
  localparam int CNT_FIELD_W = 12;

  typedef enum logic {
    FLUSH_ONE_BIN,
    FLUSH_FINAL
  } flush_kind_e;

  typedef enum logic [2:0] {
    CTRL_IDLE, CTRL_RECEIVE, CTRL_SORT, CTRL_FLUSH_ONE, CTRL_FLUSH_ALL, CTRL_FINISH
  } ctrl_state_e;

  typedef enum logic [2:0] {
    WR_IDLE, WR_REQUEST, WR_WAIT_ACK, WR_SEND_BEATS, WR_WAIT_CMPLT, WR_NEXT_BIN
  } writer_state_e;

  // flush request from the sorter to the writer
  typedef struct packed {
    logic                   valid;
    flush_kind_e            kind;
    logic [BIN_FIELD_W-1:0] bin;
    logic [CNT_FIELD_W-1:0] count;  // zero count marks the end of the final flush
  } bin_cmd_t;

  typedef struct packed {
    logic              req;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } bus_cmd_t;

  typedef struct packed {
    logic [WEIGHT_W-1:0] data;
    logic                sof_n;
    logic                eof_n;
    logic                src_rdy_n;
  } wr_beat_t;

endpackage

`default_nettype wire

// File: hw/dual_port_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dual_port_ram #(
  parameter int DEPTH = 64,
  parameter int WIDTH = 32
) (
  input  wire                     Clk,
  input  wire                     wr_en,
  input  wire [$clog2(DEPTH)-1:0] wr_addr,
  input  wire [WIDTH-1:0]         wr_data,
  input  wire                     rd_en,
  input  wire [$clog2(DEPTH)-1:0] rd_addr,
  output logic [WIDTH-1:0]        rd_data
);

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge Clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    if (rd_en) begin
      rd_data <= mem[rd_addr];  // data valid one cycle after the address
    end
  end

endmodule

`default_nettype wire

// File: hw/weight_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module weight_buffer #(
  parameter int BLOCK_WEIGHTS = 64
) (
  input  wire                              Clk,
  input  wire                              arst_n,
  input  wire                              rx_enable,
  input  wire                              stream_valid,
  input  wire [binning_pkg::WEIGHT_W-1:0]  stream_data,
  output logic                             stream_ready,
  output logic                             block_received,
  input  wire                              rd_en,
  input  wire [$clog2(BLOCK_WEIGHTS)-1:0]  rd_addr,
  output logic [binning_pkg::WEIGHT_W-1:0] rd_data
);

  localparam int AW = $clog2(BLOCK_WEIGHTS);

  logic          rx_enable_q;
  logic [AW-1:0] wr_ptr;
  logic          accept;

  assign accept = stream_valid && stream_ready;

  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_enable_q    <= 1'b0;
      wr_ptr         <= '0;
      stream_ready   <= 1'b0;
      block_received <= 1'b0;
    end else begin
      rx_enable_q    <= rx_enable;
      block_received <= 1'b0;
      if (rx_enable && !rx_enable_q) begin  // new block starts at address 0
        wr_ptr       <= '0;
        stream_ready <= 1'b1;
      end else if (accept) begin
        wr_ptr <= wr_ptr + 1'b1;
        if (wr_ptr == AW'(BLOCK_WEIGHTS - 1)) begin
          stream_ready   <= 1'b0;  // block is full
          block_received <= 1'b1;
        end
      end
    end
  end

  dual_port_ram #(
    .DEPTH (BLOCK_WEIGHTS),
    .WIDTH (binning_pkg::WEIGHT_W)
  ) ram_i (
    .Clk     (Clk),
    .wr_en   (accept),
    .wr_addr (wr_ptr),
    .wr_data (stream_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

// File: hw/bin_sorter.sv
`timescale 1ns/1ps
`default_nettype none

module bin_sorter #(
  parameter int NUM_BINS      = 16,
  parameter int BIN_DEPTH     = 8,
  parameter int BLOCK_WEIGHTS = 64
) (
  input  wire                                   Clk,
  input  wire                                   arst_n,
  input  wire                                   sort_enable,
  output logic                                  buf_rd_en,
  output logic [$clog2(BLOCK_WEIGHTS)-1:0]      buf_rd_addr,
  input  wire [binning_pkg::WEIGHT_W-1:0]       buf_rd_data,
  input  wire                                   flush_done,
  input  wire                                   final_flush,
  output binning_pkg::bin_cmd_t                 bin_cmd,
  output logic                                  sort_finished,
  input  wire [$clog2(NUM_BINS*BIN_DEPTH)-1:0]  bin_rd_addr,
  output logic [binning_pkg::WEIGHT_W-1:0]      bin_rd_data
);

  localparam int BIN_W  = $clog2(NUM_BINS);
  localparam int CNT_W  = $clog2(BIN_DEPTH + 1);
  localparam int PTR_W  = $clog2(BLOCK_WEIGHTS + 1);
  localparam int BUF_AW = $clog2(BLOCK_WEIGHTS);
  localparam int MEM_AW = $clog2(NUM_BINS * BIN_DEPTH);
  localparam int BF_W   = binning_pkg::BIN_FIELD_W;
  localparam int CF_W   = binning_pkg::CNT_FIELD_W;

  logic [CNT_W-1:0]  bin_cnt [NUM_BINS];  // words held per bin
  logic [PTR_W-1:0]  rd_ptr;
  logic              rd_valid;            // buffer data arrives this cycle
  logic              sort_done;
  logic              all_issued;
  logic [BIN_W:0]    scan_bin;            // extra bit to step past the last bin
  logic [BIN_W-1:0]  w_bin;
  logic [CNT_W-1:0]  w_cnt;
  logic [MEM_AW-1:0] bin_wr_addr;

  // one read every other cycle, paused while a flush is pending
  assign buf_rd_en = sort_enable && !bin_cmd.valid && !rd_valid &&
                     (rd_ptr < PTR_W'(BLOCK_WEIGHTS));
  assign buf_rd_addr = rd_ptr[BUF_AW-1:0];

  assign w_bin       = buf_rd_data[binning_pkg::WEIGHT_W-1 -: BIN_W];  // top bits
  assign w_cnt       = bin_cnt[w_bin];
  assign bin_wr_addr = MEM_AW'(w_bin) * MEM_AW'(BIN_DEPTH) + MEM_AW'(w_cnt);

  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int b = 0; b < NUM_BINS; b++) begin
        bin_cnt[b] <= '0;
      end
      rd_ptr        <= '0;
      rd_valid      <= 1'b0;
      sort_done     <= 1'b0;
      sort_finished <= 1'b0;
      all_issued    <= 1'b0;
      scan_bin      <= '0;
      bin_cmd       <= '0;
    end else begin
      rd_valid      <= buf_rd_en;
      sort_finished <= 1'b0;
      if (buf_rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      if (rd_valid) begin
        bin_cnt[w_bin] <= w_cnt + 1'b1;
        if (w_cnt == CNT_W'(BIN_DEPTH - 1)) begin  // this weight fills the bin
          bin_cmd <= '{valid: 1'b1, kind: binning_pkg::FLUSH_ONE_BIN,
                       bin: BF_W'(w_bin), count: CF_W'(BIN_DEPTH)};
        end
      end

      if (sort_enable && !sort_done && !rd_valid && !bin_cmd.valid &&
          rd_ptr == PTR_W'(BLOCK_WEIGHTS)) begin
        sort_done     <= 1'b1;
        sort_finished <= 1'b1;
      end

      if (flush_done) begin
        bin_cnt[bin_cmd.bin[BIN_W-1:0]] <= '0;
        bin_cmd.valid                   <= 1'b0;
        if (bin_cmd.kind == binning_pkg::FLUSH_FINAL) begin
          scan_bin <= scan_bin + 1'b1;
        end
      end

      if (bin_cmd.valid && bin_cmd.count == '0) begin
        bin_cmd.valid <= 1'b0;  // end marker lasts one cycle
      end

      ////////////////////////////////////////////////////////////////////////////
      // final flush, walk the bins in ascending order
      ////////////////////////////////////////////////////////////////////////////
      if (!final_flush) begin
        all_issued <= 1'b0;
      end else if (!bin_cmd.valid && !all_issued) begin
        if (scan_bin == (BIN_W + 1)'(NUM_BINS)) begin
          bin_cmd    <= '{valid: 1'b1, kind: binning_pkg::FLUSH_FINAL, bin: '0, count: '0};
          all_issued <= 1'b1;
          scan_bin   <= '0;
          rd_ptr     <= '0;  // ready for the next block
          sort_done  <= 1'b0;
        end else if (bin_cnt[scan_bin[BIN_W-1:0]] != '0) begin
          bin_cmd <= '{valid: 1'b1, kind: binning_pkg::FLUSH_FINAL,
                       bin: BF_W'(scan_bin[BIN_W-1:0]),
                       count: CF_W'(bin_cnt[scan_bin[BIN_W-1:0]])};
        end else begin
          scan_bin <= scan_bin + 1'b1;  // empty bin is skipped
        end
      end
    end
  end

  dual_port_ram #(
    .DEPTH (NUM_BINS * BIN_DEPTH),
    .WIDTH (binning_pkg::WEIGHT_W)
  ) bin_mem_i (
    .Clk     (Clk),
    .wr_en   (rd_valid),
    .wr_addr (bin_wr_addr),
    .wr_data (buf_rd_data),
    .rd_en   (1'b1),
    .rd_addr (bin_rd_addr),
    .rd_data (bin_rd_data)
  );

endmodule

`default_nettype wire

// File: hw/burst_writer.sv
`timescale 1ns/1ps
`default_nettype none

module burst_writer #(
  parameter int                             NUM_BINS         = 16,
  parameter int                             BIN_DEPTH        = 8,
  parameter logic [binning_pkg::ADDR_W-1:0] DRAM_BASE        = 32'h8000_0000,
  parameter int                             BIN_REGION_BYTES = 1024
) (
  input  wire                                   Clk,
  input  wire                                   arst_n,
  input  wire binning_pkg::bin_cmd_t            bin_cmd,
  output logic [$clog2(NUM_BINS*BIN_DEPTH)-1:0] bin_rd_addr,
  input  wire [binning_pkg::WEIGHT_W-1:0]       bin_rd_data,
  output binning_pkg::bus_cmd_t                 bus_cmd,
  output binning_pkg::wr_beat_t                 wr_beat,
  input  wire                                   cmd_ack,
  input  wire                                   cmd_cmplt,
  input  wire                                   dst_rdy_n,
  output logic                                  flush_done,
  output logic                                  all_flushed
);

  localparam int BIN_W  = $clog2(NUM_BINS);
  localparam int CNT_W  = $clog2(BIN_DEPTH + 1);
  localparam int MEM_AW = $clog2(NUM_BINS * BIN_DEPTH);
  localparam int EXT_W  = $clog2(BIN_REGION_BYTES);  // words already sent per bin
  localparam int AW     = binning_pkg::ADDR_W;
  localparam int LW     = binning_pkg::LEN_W;

  binning_pkg::writer_state_e state;

  logic [BIN_W-1:0] cur_bin;
  logic [CNT_W-1:0] cur_cnt;
  logic [CNT_W-1:0] rd_idx;             // word now on bin_rd_data
  logic [EXT_W-1:0] ext_cnt [NUM_BINS];
  logic             beat_xfer;
  logic             load_beat;
  logic [AW-1:0]    burst_addr;

  assign beat_xfer = (state == binning_pkg::WR_SEND_BEATS) && !wr_beat.src_rdy_n && !dst_rdy_n;
  assign load_beat = ((state == binning_pkg::WR_WAIT_ACK) && cmd_ack) ||
                     (beat_xfer && wr_beat.eof_n);

  // address runs one word ahead so beats go back to back
  assign bin_rd_addr = MEM_AW'(cur_bin) * MEM_AW'(BIN_DEPTH) +
                       MEM_AW'(load_beat ? rd_idx + 1'b1 : rd_idx);

  assign burst_addr = DRAM_BASE + AW'(cur_bin) * AW'(BIN_REGION_BYTES) +
                      AW'({ext_cnt[cur_bin], 2'b00});

  assign flush_done = (state == binning_pkg::WR_NEXT_BIN);

  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= binning_pkg::WR_IDLE;
      cur_bin <= '0;
      cur_cnt <= '0;
      rd_idx  <= '0;
      for (int b = 0; b < NUM_BINS; b++) begin
        ext_cnt[b] <= '0;
      end
      bus_cmd     <= '0;
      wr_beat     <= '{data: '0, sof_n: 1'b1, eof_n: 1'b1, src_rdy_n: 1'b1};
      all_flushed <= 1'b0;
    end else begin
      all_flushed <= 1'b0;

      if (load_beat) begin
        rd_idx            <= rd_idx + 1'b1;
        wr_beat.data      <= bin_rd_data;
        wr_beat.sof_n     <= (state == binning_pkg::WR_SEND_BEATS);  // low on the first
        wr_beat.eof_n     <= (rd_idx != cur_cnt - 1'b1);
        wr_beat.src_rdy_n <= 1'b0;
      end

      ////////////////////////////////////////////////////////////////////////////
      // write command and burst sequence
      ////////////////////////////////////////////////////////////////////////////
      case (state)
        binning_pkg::WR_IDLE: begin
          rd_idx <= '0;
          if (bin_cmd.valid) begin
            if (bin_cmd.count == '0) begin  // every bin has gone out
              all_flushed <= 1'b1;
              for (int b = 0; b < NUM_BINS; b++) begin
                ext_cnt[b] <= '0;
              end
            end else begin
              cur_bin <= bin_cmd.bin[BIN_W-1:0];
              cur_cnt <= bin_cmd.count[CNT_W-1:0];
              state   <= binning_pkg::WR_REQUEST;
            end
          end
        end
        binning_pkg::WR_REQUEST: begin
          bus_cmd <= '{req: 1'b1, addr: burst_addr, len: LW'({cur_cnt, 2'b00})};
          state   <= binning_pkg::WR_WAIT_ACK;
        end
        binning_pkg::WR_WAIT_ACK: begin
          if (cmd_ack) begin
            bus_cmd.req <= 1'b0;
            state       <= binning_pkg::WR_SEND_BEATS;
          end
        end
        binning_pkg::WR_SEND_BEATS: begin
          if (beat_xfer && !wr_beat.eof_n) begin
            wr_beat.sof_n     <= 1'b1;
            wr_beat.eof_n     <= 1'b1;
            wr_beat.src_rdy_n <= 1'b1;
            state             <= binning_pkg::WR_WAIT_CMPLT;
          end
        end
        binning_pkg::WR_WAIT_CMPLT: begin
          if (cmd_cmplt) begin
            ext_cnt[cur_bin] <= ext_cnt[cur_bin] + EXT_W'(cur_cnt);
            state            <= binning_pkg::WR_NEXT_BIN;
          end
        end
        binning_pkg::WR_NEXT_BIN: begin
          state <= binning_pkg::WR_IDLE;
        end
        default: begin
          state <= binning_pkg::WR_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/binning_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module binning_ctrl (
  input  wire  Clk,
  input  wire  arst_n,
  input  wire  start,
  input  wire  block_received,
  input  wire  sort_finished,
  input  wire  bin_full,        // sorter holds a full-bin flush
  input  wire  flush_done,
  input  wire  all_flushed,
  output logic rx_enable,
  output logic sort_enable,
  output logic final_flush,
  output logic done
);

  binning_pkg::ctrl_state_e state;
  binning_pkg::ctrl_state_e state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      binning_pkg::CTRL_IDLE: begin
        if (start) begin
          state_nxt = binning_pkg::CTRL_RECEIVE;
        end
      end
      binning_pkg::CTRL_RECEIVE: begin
        if (block_received) begin
          state_nxt = binning_pkg::CTRL_SORT;
        end
      end
      binning_pkg::CTRL_SORT: begin
        if (sort_finished) begin
          state_nxt = binning_pkg::CTRL_FLUSH_ALL;
        end else if (bin_full) begin
          state_nxt = binning_pkg::CTRL_FLUSH_ONE;
        end
      end
      binning_pkg::CTRL_FLUSH_ONE: begin
        if (flush_done) begin
          state_nxt = binning_pkg::CTRL_SORT;  // back to sorting
        end
      end
      binning_pkg::CTRL_FLUSH_ALL: begin
        if (all_flushed) begin
          state_nxt = binning_pkg::CTRL_FINISH;
        end
      end
      default: state_nxt = binning_pkg::CTRL_IDLE;
    endcase
  end

  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= binning_pkg::CTRL_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign rx_enable   = (state == binning_pkg::CTRL_RECEIVE);
  assign sort_enable = (state == binning_pkg::CTRL_SORT);
  assign final_flush = (state == binning_pkg::CTRL_FLUSH_ALL);
  assign done        = (state == binning_pkg::CTRL_FINISH);  // one cycle after all_flushed

endmodule

`default_nettype wire

// File: hw/weight_binner.sv
`timescale 1ns/1ps
`default_nettype none

module weight_binner #(
  parameter int                             NUM_BINS         = 16,  // power of two
  parameter int                             BIN_DEPTH        = 8,
  parameter int                             BLOCK_WEIGHTS    = 64,
  parameter logic [binning_pkg::ADDR_W-1:0] DRAM_BASE        = 32'h8000_0000,
  parameter int                             BIN_REGION_BYTES = 1024
) (
  input  wire                             Clk,
  input  wire                             arst_n,
  input  wire                             stream_valid,
  input  wire [binning_pkg::WEIGHT_W-1:0] stream_data,
  output logic                            stream_ready,
  input  wire                             start,
  output logic                            done,
  output binning_pkg::bus_cmd_t           bus_cmd,
  output binning_pkg::wr_beat_t           wr_beat,
  input  wire                             cmd_ack,
  input  wire                             cmd_cmplt,
  input  wire                             dst_rdy_n
);

  ////////////////////////////////////////////////////////////////////////////
  // internal wiring
  ////////////////////////////////////////////////////////////////////////////
  logic                                   rx_enable;
  logic                                   block_received;
  logic                                   buf_rd_en;
  logic [$clog2(BLOCK_WEIGHTS)-1:0]       buf_rd_addr;
  logic [binning_pkg::WEIGHT_W-1:0]       buf_rd_data;
  logic                                   sort_enable;
  logic                                   sort_finished;
  logic                                   final_flush;
  logic                                   flush_done;
  logic                                   all_flushed;
  binning_pkg::bin_cmd_t                  bin_cmd;
  logic [$clog2(NUM_BINS*BIN_DEPTH)-1:0]  bin_rd_addr;
  logic [binning_pkg::WEIGHT_W-1:0]       bin_rd_data;

  weight_buffer #(
    .BLOCK_WEIGHTS (BLOCK_WEIGHTS)
  ) weight_buffer_i (
    .Clk            (Clk),
    .arst_n         (arst_n),
    .rx_enable      (rx_enable),
    .stream_valid   (stream_valid),
    .stream_data    (stream_data),
    .stream_ready   (stream_ready),
    .block_received (block_received),
    .rd_en          (buf_rd_en),
    .rd_addr        (buf_rd_addr),
    .rd_data        (buf_rd_data)
  );

  bin_sorter #(
    .NUM_BINS      (NUM_BINS),
    .BIN_DEPTH     (BIN_DEPTH),
    .BLOCK_WEIGHTS (BLOCK_WEIGHTS)
  ) bin_sorter_i (
    .Clk           (Clk),
    .arst_n        (arst_n),
    .sort_enable   (sort_enable),
    .buf_rd_en     (buf_rd_en),
    .buf_rd_addr   (buf_rd_addr),
    .buf_rd_data   (buf_rd_data),
    .flush_done    (flush_done),
    .final_flush   (final_flush),
    .bin_cmd       (bin_cmd),
    .sort_finished (sort_finished),
    .bin_rd_addr   (bin_rd_addr),
    .bin_rd_data   (bin_rd_data)
  );

  burst_writer #(
    .NUM_BINS         (NUM_BINS),
    .BIN_DEPTH        (BIN_DEPTH),
    .DRAM_BASE        (DRAM_BASE),
    .BIN_REGION_BYTES (BIN_REGION_BYTES)
  ) burst_writer_i (
    .Clk         (Clk),
    .arst_n      (arst_n),
    .bin_cmd     (bin_cmd),
    .bin_rd_addr (bin_rd_addr),
    .bin_rd_data (bin_rd_data),
    .bus_cmd     (bus_cmd),
    .wr_beat     (wr_beat),
    .cmd_ack     (cmd_ack),
    .cmd_cmplt   (cmd_cmplt),
    .dst_rdy_n   (dst_rdy_n),
    .flush_done  (flush_done),
    .all_flushed (all_flushed)
  );

  binning_ctrl binning_ctrl_i (
    .Clk            (Clk),
    .arst_n         (arst_n),
    .start          (start),
    .block_received (block_received),
    .sort_finished  (sort_finished),
    .bin_full       (bin_cmd.valid && (bin_cmd.kind == binning_pkg::FLUSH_ONE_BIN)),
    .flush_done     (flush_done),
    .all_flushed    (all_flushed),
    .rx_enable      (rx_enable),
    .sort_enable    (sort_enable),
    .final_flush    (final_flush),
    .done           (done)
  );

endmodule

`default_nettype wire

// File: verif/bus_target_model.sv
`timescale 1ns/1ps
`default_nettype none

module bus_target_model (
  input  wire                   Clk,
  input  wire                   arst_n,
  input  wire binning_pkg::bus_cmd_t bus_cmd,
  input  wire binning_pkg::wr_beat_t wr_beat,
  output logic                  cmd_ack,
  output logic                  cmd_cmplt,
  output logic                  dst_rdy_n
);

  integer seed = 32'h9383b2e0;

  // one entry per acknowledged command
  logic [31:0] addr_q [$];
  logic [31:0] len_q [$];
  int          first_q [$];  // index of the first beat in data_q

  // one entry per transferred beat
  logic [31:0] data_q [$];
  bit          sof_q [$];
  bit          eof_q [$];

  int ack_wait;
  int cmplt_wait;

  // quiet bus until the first falling edge
  initial begin
    cmd_ack    = 1'b0;
    cmd_cmplt  = 1'b0;
    dst_rdy_n  = 1'b1;
    ack_wait   = -1;
    cmplt_wait = -1;
  end

  // outputs change on the falling edge, the DUT samples them on the rising edge
  always @(negedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      cmd_ack    = 1'b0;
      cmd_cmplt  = 1'b0;
      dst_rdy_n  = 1'b1;
      ack_wait   = -1;
      cmplt_wait = -1;
    end else begin
      cmd_ack   = 1'b0;
      cmd_cmplt = 1'b0;
      if (bus_cmd.req) begin
        if (ack_wait < 0) begin
          ack_wait = {$random(seed)} % 5;  // random acknowledge delay
        end
        if (ack_wait == 0) begin
          cmd_ack = 1'b1;
          addr_q.push_back(bus_cmd.addr);
          len_q.push_back(32'(bus_cmd.len));
          first_q.push_back(data_q.size());
          ack_wait = -1;
        end else begin
          ack_wait--;
        end
      end
      if (cmplt_wait == 0) begin
        cmd_cmplt  = 1'b1;
        cmplt_wait = -1;
      end else if (cmplt_wait > 0) begin
        cmplt_wait--;
      end
      dst_rdy_n = ({$random(seed)} % 3) == 0;  // stall about a third of the cycles
      // the beat on the bus now transfers at the next rising edge
      if (!wr_beat.src_rdy_n && !dst_rdy_n) begin
        data_q.push_back(wr_beat.data);
        sof_q.push_back(!wr_beat.sof_n);
        eof_q.push_back(!wr_beat.eof_n);
        if (!wr_beat.eof_n) begin
          cmplt_wait = {$random(seed)} % 4;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_weight_binner.sv
`timescale 1ns/1ps
`default_nettype none

module tb_weight_binner;

  localparam int          NUM_BINS         = 16;
  localparam int          BIN_DEPTH        = 8;
  localparam int          BLOCK_WEIGHTS    = 64;
  localparam logic [31:0] DRAM_BASE        = 32'h8000_0000;
  localparam int          BIN_REGION_BYTES = 1024;
  localparam int          BIN_W            = $clog2(NUM_BINS);
  localparam int          TIMEOUT          = 20000;
  localparam int          HOT_BIN          = 5;

  logic                  Clk;
  logic                  arst_n;
  logic                  stream_valid;
  logic [31:0]           stream_data;
  logic                  stream_ready;
  logic                  start;
  logic                  done;
  binning_pkg::bus_cmd_t bus_cmd;
  binning_pkg::wr_beat_t wr_beat;
  logic                  cmd_ack;
  logic                  cmd_cmplt;
  logic                  dst_rdy_n;

  integer      seed = 32'h9383b2e0;
  logic [31:0] sent_q [$];          // weights of the current block in stream order
  int          bin_ptr [NUM_BINS];  // next unmatched position per bin
  int          exp_words [NUM_BINS];
  int          burst_base;
  logic        req_q;
  logic        ack_q;

  weight_binner #(
    .NUM_BINS         (NUM_BINS),
    .BIN_DEPTH        (BIN_DEPTH),
    .BLOCK_WEIGHTS    (BLOCK_WEIGHTS),
    .DRAM_BASE        (DRAM_BASE),
    .BIN_REGION_BYTES (BIN_REGION_BYTES)
  ) weight_binner_i (
    .Clk          (Clk),
    .arst_n       (arst_n),
    .stream_valid (stream_valid),
    .stream_data  (stream_data),
    .stream_ready (stream_ready),
    .start        (start),
    .done         (done),
    .bus_cmd      (bus_cmd),
    .wr_beat      (wr_beat),
    .cmd_ack      (cmd_ack),
    .cmd_cmplt    (cmd_cmplt),
    .dst_rdy_n    (dst_rdy_n)
  );

  bus_target_model bus_model_i (
    .Clk       (Clk),
    .arst_n    (arst_n),
    .bus_cmd   (bus_cmd),
    .wr_beat   (wr_beat),
    .cmd_ack   (cmd_ack),
    .cmd_cmplt (cmd_cmplt),
    .dst_rdy_n (dst_rdy_n)
  );

  initial begin
    Clk = 1'b0;
    forever #5 Clk = ~Clk;
  end

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1);
  endtask

  // request must hold until an acknowledge was seen
  always @(posedge Clk) begin
    ack_q <= cmd_ack;
  end

  always @(negedge Clk) begin
    if (arst_n) begin
      if (req_q && !ack_q) begin
        assert (bus_cmd.req) else fail_now("bus_cmd.req dropped before cmd_ack");
      end
      req_q = bus_cmd.req;
    end
  end

  function automatic int next_of_bin(input int bin, input int from);
    for (int i = from; i < sent_q.size(); i++) begin
      if (int'(sent_q[i][31 -: BIN_W]) == bin) begin
        return i;
      end
    end
    return -1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // burst scoreboard for one block
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_block();
    int          first;
    int          nbeats;
    int          bin;
    int          pos;
    int          last_final;
    bit          final_seen;
    logic [31:0] addr;
    logic [31:0] len;
    logic [31:0] exp_addr;
    final_seen = 1'b0;
    last_final = -1;
    for (int b = burst_base; b < bus_model_i.addr_q.size(); b++) begin
      addr   = bus_model_i.addr_q[b];
      len    = bus_model_i.len_q[b];
      first  = bus_model_i.first_q[b];
      nbeats = (b + 1 < bus_model_i.first_q.size()) ? bus_model_i.first_q[b + 1] - first
                                                     : bus_model_i.data_q.size() - first;
      bin = int'((addr - DRAM_BASE) / BIN_REGION_BYTES);
      assert (bin < NUM_BINS) else
        fail_now($sformatf("ERROR bus_cmd.addr out of range: 0x%08h", addr));
      exp_addr = DRAM_BASE + bin * BIN_REGION_BYTES + 4 * exp_words[bin];
      assert (addr == exp_addr) else
        fail_now($sformatf("ERROR bus_cmd.addr got 0x%08h expected 0x%08h", addr, exp_addr));
      assert (len > 0 && len <= BIN_DEPTH * 4 && len % 4 == 0) else
        fail_now($sformatf("ERROR bus_cmd.len bad value 0x%05h", len));
      assert (nbeats == int'(len / 4)) else
        fail_now($sformatf("ERROR beat count got 0x%0h expected 0x%0h", nbeats, len / 4));
      if (len != BIN_DEPTH * 4) begin
        final_seen = 1'b1;
      end else begin
        assert (!final_seen) else fail_now("full-bin burst seen during the final flush");
      end
      if (final_seen) begin
        assert (bin > last_final) else
          fail_now($sformatf("ERROR final flush bin 0x%0h after bin 0x%0h", bin, last_final));
        last_final = bin;
      end
      for (int j = 0; j < nbeats; j++) begin
        assert (bus_model_i.sof_q[first + j] == (j == 0)) else
          fail_now($sformatf("ERROR wr_beat.sof_n got 0x%0h expected 0x%0h on beat %0d",
                             !bus_model_i.sof_q[first + j], j != 0, j));
        assert (bus_model_i.eof_q[first + j] == (j == nbeats - 1)) else
          fail_now($sformatf("ERROR wr_beat.eof_n got 0x%0h expected 0x%0h on beat %0d",
                             !bus_model_i.eof_q[first + j], j != nbeats - 1, j));
        pos = next_of_bin(bin, bin_ptr[bin]);
        assert (pos >= 0 && sent_q[pos] == bus_model_i.data_q[first + j]) else
          fail_now($sformatf("ERROR wr_beat.data got 0x%08h expected 0x%08h",
                             bus_model_i.data_q[first + j], (pos >= 0) ? sent_q[pos] : 'x));
        bin_ptr[bin] = pos + 1;
      end
      exp_words[bin] += nbeats;
    end
    for (int k = 0; k < NUM_BINS; k++) begin
      assert (next_of_bin(k, bin_ptr[k]) < 0) else
        fail_now($sformatf("weight of bin %0d never written to memory", k));
    end
    burst_base = bus_model_i.addr_q.size();
  endtask

  task automatic run_block();
    int  timer;
    bit  accepted;
    sent_q.delete();
    for (int k = 0; k < NUM_BINS; k++) begin
      bin_ptr[k]   = 0;
      exp_words[k] = 0;
    end
    @(negedge Clk);
    start = 1'b1;
    @(negedge Clk);
    start = 1'b0;
    timer = 0;
    while (!stream_ready) begin
      @(negedge Clk);
      timer++;
      if (timer > 100) fail_now("timeout waiting for stream_ready");
    end
    accepted = 1'b0;
    timer    = 0;
    while (sent_q.size() < BLOCK_WEIGHTS) begin
      if (accepted) begin
        sent_q.push_back(stream_data);
      end
      if (sent_q.size() < BLOCK_WEIGHTS) begin
        stream_valid = ({$random(seed)} % 4) != 0;  // gaps in the stream
        stream_data  = $random(seed);
        if (({$random(seed)} % 2) == 0) begin
          stream_data[31 -: BIN_W] = BIN_W'(HOT_BIN);  // crowd one bin so it fills up
        end
        accepted     = stream_valid && stream_ready;
        @(negedge Clk);
      end
      timer++;
      if (timer > 1000) fail_now("timeout while sending the stream");
    end
    stream_valid = 1'b0;
    assert (!stream_ready) else fail_now("ERROR stream_ready got 0x1 expected 0x0");
    timer = 0;
    while (!done) begin
      @(negedge Clk);
      assert (!stream_ready) else fail_now("ERROR stream_ready got 0x1 expected 0x0");
      timer++;
      if (timer > TIMEOUT) fail_now("timeout waiting for done");
    end
    @(negedge Clk);
    assert (!done) else fail_now("ERROR done got 0x1 expected 0x0");
    check_block();
  endtask

  initial begin
    arst_n       = 1'b0;
    stream_valid = 1'b0;
    stream_data  = '0;
    start        = 1'b0;
    req_q        = 1'b0;
    ack_q        = 1'b0;
    burst_base   = 0;
    repeat (5) @(negedge Clk);
    arst_n = 1'b1;
    @(negedge Clk);
    assert (!stream_ready) else fail_now("ERROR stream_ready got 0x1 expected 0x0");
    assert (!bus_cmd.req) else fail_now("ERROR bus_cmd.req got 0x1 expected 0x0");
    assert (!done) else fail_now("ERROR done got 0x1 expected 0x0");
    assert (wr_beat.src_rdy_n) else fail_now("ERROR wr_beat.src_rdy_n got 0x0 expected 0x1");
    run_block();
    run_block();  // second block right behind the first
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: weight_binner.f
hw/binning_pkg.sv
hw/dual_port_ram.sv
hw/weight_buffer.sv
hw/bin_sorter.sv
hw/burst_writer.sv
hw/binning_ctrl.sv
hw/weight_binner.sv
verif/bus_target_model.sv
verif/tb_weight_binner.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_weight_binner \
  -f weight_binner.f -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Errors found" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
if ! grep -q "No errors" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
